/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mic_frontend_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = ** FAIL **
PASS_MSG  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/mic_cases.txt */
// left raw word, right raw word, 18-bit hex, one frame per line
// left words reach the window with the offset added, right words never do
00000 3ffff
00001 2aaaa
3ffff 15555
3e3c0 00000
3e3bf 12345
3fff0 0f0f0
1c40e 3c3c3
20000 01234
1ffff 3edcb
0abcd 2fedc
15555 0aaaa
2aaaa 35555
3f000 1f1f1
00fff 2e2e2
12345 3a5a5
3c000 05a5a
0f0f0 30303
30303 0f0f0
3a5a5 1234f
05a5a 3ffff
3ff00 22222
11111 33333
2c0de 0cafe
3e3c1 1beef

/* dv/mic_frontend_properties.sv */
`timescale 1ns/1ns

module mic_frontend_properties (
	input logic clk,
	input logic reset,
	input logic bclk,
	input logic lrclk,
	input logic new_window
);

	// Word select only moves at a falling bit clock
	lrclk_on_bclk_fall: assert property (
		@(posedge clk) disable iff (!reset)
		(lrclk != $past(lrclk)) |-> $fell(bclk)
	) else $error("lrclk changed in a cycle where bclk did not fall");

	// Bit clock high for two clk cycles, then low
	bclk_half_period: assert property (
		@(posedge clk) disable iff (!reset)
		$rose(bclk) |=> bclk ##1 !bclk
	) else $error("bclk high phase is not two clk cycles");

	// Single-cycle window strobe
	new_window_single: assert property (
		@(posedge clk) disable iff (!reset)
		new_window |=> !new_window
	) else $error("new_window high for two cycles in a row");

	// Strobe belongs to the left word
	new_window_left_only: assert property (
		@(posedge clk) disable iff (!reset)
		new_window |-> !lrclk
	) else $error("new_window high while lrclk is high");

endmodule

// Attached to every instance of the front end
bind mic_frontend mic_frontend_properties frontend_props (
	.clk        (clk),
	.reset      (reset),
	.bclk       (bclk),
	.lrclk      (lrclk),
	.new_window (new_window)
);

/* dv/mic_frontend_tb.sv */
`timescale 1ns/1ns

module mic_frontend_tb;
	import mic_pkg::*;

	// Run length
	localparam int num_frames = 24;
	localparam int frame_cycles = 256;
	localparam int timeout_cycles = num_frames * frame_cycles + 512;
	localparam int frames_before_reset = 20;

	// Microphone word format
	localparam int data_bits = 18;
	localparam sample_t cal_value = 18'd7232;

	logic    clk = 1'b0;
	logic    reset = 1'b0;
	logic    dout = 1'b0;
	logic    bclk;
	logic    lrclk;
	logic    new_window;
	window_t window;

	// Left word at even address, right word at odd
	sample_t case_words [0:2*num_frames-1];

	// Error count per test, slot 0 unused
	int   errs [0:5];
	int   checks_run = 0;
	int   cycle_count = 0;
	logic after_mid_reset = 1'b0;

	// Microphone model
	sample_t     mic_word = 18'h15555;
	int          bit_idx = 0;
	logic        lr_seen = 1'b1;
	logic        bclk_seen = 1'b1;
	int          left_sent = 0;
	logic [31:0] lfsr = 32'h3816;

	// Clock shape monitor
	int   rise_gap = 0;
	int   rises_in_word = 0;
	int   lr_toggles = 0;
	logic gap_armed = 1'b0;
	logic bclk_q = 1'b1;
	logic lrclk_q = 1'b1;

	// Window checker, newest expected sample first
	sample_t history [$];
	int      pulse_count = 0;
	int      since_pulse = 0;
	logic    spacing_armed = 1'b0;

	mic_frontend uut (
		.clk        (clk),
		.reset      (reset),
		.dout       (dout),
		.bclk       (bclk),
		.lrclk      (lrclk),
		.new_window (new_window),
		.window     (window)
	);

	always #20 clk = ~clk;

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	task automatic check_value(input int test, input string name,
			input logic [31:0] expected, input logic [31:0] actual);
		checks_run++;
		assert (actual == expected) else begin
			$display("[FAIL] t=%0t %s: expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
			errs[3'(test)]++;
		end
	endtask

	task automatic show_result(input int test, input string title);
		if (errs[3'(test)] == 0) begin
			$display("test %0d %s: ok", test, title);
		end else begin
			$display("test %0d %s: %0d errors", test, title, errs[3'(test)]);
		end
	endtask

	// Eight cycles of reset, outputs checked once the DUT has seen it
	task automatic hold_reset(input int test);
		reset <= 1'b0;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			if (i >= 1) begin
				check_value(test, "bclk", 32'd1, 32'(bclk));
				check_value(test, "lrclk", 32'd1, 32'(lrclk));
				check_value(test, "new_window", 0, 32'(new_window));
				for (int k = 0; k < 16; k++) begin
					check_value(test, $sformatf("window[%0d]", k), 0, 32'(window[4'(k)]));
				end
			end
		end
		reset <= 1'b1;
	endtask

	// Microphone: next bit after each falling bclk
	always @(posedge clk) begin
		if (!reset) begin
			dout <= 1'b0;
			bit_idx = 0;
			lr_seen = 1'b1;
			bclk_seen = 1'b1;
		end else begin
			if (!bclk && bclk_seen) begin
				if (lrclk != lr_seen) begin
					// Word boundary, MSB goes out in slot 0
					bit_idx = 0;
					if (!lrclk) begin
						mic_word = case_words[6'(2 * left_sent)];
						left_sent++;
					end else begin
						mic_word = case_words[6'(2 * left_sent - 1)];
					end
					lr_seen = lrclk;
				end else begin
					bit_idx++;
				end
				if (bit_idx < data_bits) begin
					dout <= mic_word[17];
					mic_word = mic_word << 1;
				end else begin
					// Tail slots carry noise
					dout <= lfsr[0];
					lfsr = lfsr_next(lfsr);
				end
			end
			bclk_seen = bclk;
		end
	end

	// bclk period and word length
	always @(posedge clk) begin
		int shape_test;
		shape_test = after_mid_reset ? 5 : 1;
		if (!reset) begin
			rise_gap = 0;
			rises_in_word = 0;
			lr_toggles = 0;
			gap_armed = 1'b0;
			bclk_q = 1'b1;
			lrclk_q = 1'b1;
		end else begin
			rise_gap++;
			if (bclk && !bclk_q) begin
				if (gap_armed) begin
					check_value(shape_test, "bclk period in clk cycles", 4, rise_gap);
				end
				gap_armed = 1'b1;
				rise_gap = 0;
				rises_in_word++;
			end
			if (lrclk != lrclk_q) begin
				// First word after reset is partial
				if (lr_toggles > 0) begin
					check_value(shape_test, "bclk periods per lrclk word", 32, rises_in_word);
				end
				lr_toggles++;
				rises_in_word = 0;
			end
			bclk_q = bclk;
			lrclk_q = lrclk;
		end
	end

	// Window contents at each strobe
	always @(posedge clk) begin
		sample_t expected;
		sample_t entry_exp;
		int      first_test;
		int      rest_test;
		int      rate_test;
		first_test = after_mid_reset ? 5 : 2;
		rest_test = after_mid_reset ? 5 : 4;
		rate_test = after_mid_reset ? 5 : 3;
		if (!reset) begin
			since_pulse = 0;
			spacing_armed = 1'b0;
		end else begin
			since_pulse++;
			if (new_window) begin
				// Raw left word plus offset, wraps at 18 bits
				expected = case_words[6'(2 * pulse_count)] + cal_value;
				history.push_front(expected);
				if (history.size() > 16) begin
					void'(history.pop_back());
				end
				check_value(first_test, "window[0]", 32'(expected), 32'(window[0]));
				for (int k = 1; k < 16; k++) begin
					entry_exp = (k < history.size()) ? history[k] : '0;
					check_value(rest_test, $sformatf("window[%0d]", k),
						32'(entry_exp), 32'(window[4'(k)]));
				end
				check_value(rate_test, "lrclk at new_window", 0, 32'(lrclk));
				// One strobe per frame
				if (spacing_armed) begin
					check_value(rate_test, "clk cycles between new_window", frame_cycles,
						since_pulse);
				end
				spacing_armed = 1'b1;
				since_pulse = 0;
				pulse_count++;
			end
		end
	end

	initial begin
		int total;
		errs = '{default: 0};
		$readmemh("dv/mic_cases.txt", case_words);
		hold_reset(1);
		while (lr_toggles < 4) begin
			@(posedge clk);
		end
		show_result(1, "reset and clock shape");
		while (pulse_count < frames_before_reset) begin
			@(posedge clk);
		end
		show_result(2, "capture and calibration");
		show_result(3, "right channel and tail bits ignored");
		show_result(4, "window order");
		// Mid-run reset, window starts over
		@(posedge clk);
		after_mid_reset <= 1'b1;
		history.delete();
		hold_reset(5);
		while (pulse_count < num_frames) begin
			@(posedge clk);
		end
		show_result(5, "reset in mid-run");
		total = errs[1] + errs[2] + errs[3] + errs[4] + errs[5];
		$display("checks run %0d, failed %0d", checks_run, total);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog
	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d clk cycles", timeout_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* src/fft_sample_window.sv */
`timescale 1ns/1ns

module fft_sample_window (
	input  logic             clk,
	input  logic             reset,
	input  mic_pkg::sample_t sample,
	input  logic             sample_valid,
	output mic_pkg::window_t window,
	output logic             new_window
);
	import mic_pkg::*;

	// Sliding window of calibrated samples
	// Entry 0 newest, entry 15 oldest
	always_ff @(posedge clk) begin
		if (!reset) begin
			window <= '0;
		end else if (sample_valid) begin
			// Every entry ages by one place
			for (int k = window_depth - 1; k > 0; k--) begin
				window[k] <= window[k-1];
			end
			// Newest sample enters at the front
			window[0] <= sample;
		end
	end

	// Strobe for the FFT
	// Window already holds the new sample when this is high
	always_ff @(posedge clk) begin
		if (!reset) begin
			new_window <= 1'b0;
		end else begin
			new_window <= sample_valid;
		end
	end

endmodule

/* src/i2s_clock_gen.sv */
`timescale 1ns/1ns

module i2s_clock_gen (
	input  logic           clk,
	input  logic           reset,
	output logic           bclk,
	output logic           lrclk,
	output mic_pkg::slot_t slot,
	output logic           bit_strobe
);
	import mic_pkg::*;

	// Position inside one bit clock period
	logic [1:0] phase;
	logic [1:0] phase_next;

	// Cycle where bclk goes low
	logic       bclk_fall;

	// Slot 31 of the current word
	logic       last_slot;

	// Phase counter wraps once per bclk period
	always_comb begin
		if (phase == 2'(bclk_div - 1)) begin
			phase_next = '0;
		end else begin
			phase_next = phase + 2'd1;
		end
	end

	// First half of the period is high
	// So the fall is at the start of the second half
	assign bclk_fall = (phase_next == 2'(bclk_div / 2));

	assign last_slot = (slot == slot_t'(slot_count - 1));

	// Bit clock and sampling strobe
	always_ff @(posedge clk) begin
		if (!reset) begin
			phase      <= '0;
			bclk       <= 1'b1;
			bit_strobe <= 1'b0;
		end else begin
			phase      <= phase_next;
			// High for phases 0 and 1
			bclk       <= (phase_next < 2'(bclk_div / 2));
			// Pulse in the same cycle bclk rises
			bit_strobe <= (phase_next == '0);
		end
	end

	// Slot index and word select
	// Both move with the falling bclk, same as mic data
	always_ff @(posedge clk) begin
		if (!reset) begin
			slot  <= '0;
			// Right channel comes first
			lrclk <= 1'b1;
		end else if (bclk_fall) begin
			if (last_slot) begin
				slot  <= '0;
				// Word boundary
				lrclk <= ~lrclk;
			end else begin
				slot <= slot + slot_t'(1);
			end
		end
	end

endmodule

/* src/mic_frontend.sv */
`timescale 1ns/1ns

module mic_frontend (
	input  logic             clk,
	input  logic             reset,
	input  logic             dout,
	output logic             bclk,
	output logic             lrclk,
	output logic             new_window,
	output mic_pkg::window_t window
);
	import mic_pkg::*;

	// Bit slot index from the clock generator
	slot_t   slot;

	// High in the cycle bclk rises
	logic    bit_strobe;

	// Calibrated left-channel word
	sample_t sample;
	logic    sample_valid;

	// Bit clock and word select for the microphone
	i2s_clock_gen u_clock_gen (
		.clk        (clk),
		.reset      (reset),
		.bclk       (bclk),
		.lrclk      (lrclk),
		.slot       (slot),
		.bit_strobe (bit_strobe)
	);

	// Serial data in, left word out with offset added
	mic_sample_receiver u_receiver (
		.clk          (clk),
		.reset        (reset),
		.dout         (dout),
		.lrclk        (lrclk),
		.slot         (slot),
		.bit_strobe   (bit_strobe),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	// Sixteen newest samples for the FFT
	fft_sample_window u_window (
		.clk          (clk),
		.reset        (reset),
		.sample       (sample),
		.sample_valid (sample_valid),
		.window       (window),
		.new_window   (new_window)
	);

endmodule

/* src/mic_pkg.sv */
package mic_pkg;

	// Frame format of the I2S MEMS microphone

	// Data bits kept per word
	localparam int sample_bits = 18;

	// Bit clock periods per word
	localparam int slot_count = 32;

	// System clocks per bit clock period
	localparam int bclk_div = 4;

	// Samples handed to the 16-point FFT
	localparam int window_depth = 16;

	// Raw or calibrated microphone word
	typedef logic [sample_bits-1:0] sample_t;

	// Bit slot within one word
	typedef logic [$clog2(slot_count)-1:0] slot_t;

	// Entry 0 holds the newest sample
	typedef sample_t [window_depth-1:0] window_t;

	// DC base level correction, 226 * 32
	// Added modulo 2**18 so large words wrap
	localparam sample_t cal_offset = sample_t'(226 * 32);

endpackage

/* src/mic_sample_receiver.sv */
`timescale 1ns/1ns

module mic_sample_receiver (
	input  logic             clk,
	input  logic             reset,
	input  logic             dout,
	input  logic             lrclk,
	input  mic_pkg::slot_t   slot,
	input  logic             bit_strobe,
	output mic_pkg::sample_t sample,
	output logic             sample_valid
);
	import mic_pkg::*;

	// Serial bits of the current word, MSB first
	sample_t shift_reg;

	// Shift register after taking the current bit
	sample_t next_word;

	// Slot decodes
	logic    capture_slot;
	logic    final_slot;
	logic    clear_slot;

	// Last bit of a left word arrives now
	logic    left_done;

	// Slots 0 to 17 carry data
	assign capture_slot = (slot < slot_t'(sample_bits));

	// Slot 17 holds the LSB
	assign final_slot = (slot == slot_t'(sample_bits - 1));

	// Slot 18 starts the unused tail
	assign clear_slot = (slot == slot_t'(sample_bits));

	assign next_word = {shift_reg[sample_bits-2:0], dout};

	// Word select low means left channel
	assign left_done = bit_strobe && final_slot && !lrclk;

	// Deserializer
	always_ff @(posedge clk) begin
		if (!reset) begin
			shift_reg <= '0;
		end else if (bit_strobe) begin
			if (capture_slot) begin
				shift_reg <= next_word;
			end else if (clear_slot) begin
				// Tail bits never reach the next word
				shift_reg <= '0;
			end
		end
	end

	// Calibrated sample
	// Includes the slot-17 bit taken in this same cycle
	// Wraps modulo 2**18 through the sample_t width
	always_ff @(posedge clk) begin
		if (left_done) begin
			sample <= next_word + cal_offset;
		end
	end

	// One pulse per left word
	// Right-channel words end here too but are dropped
	always_ff @(posedge clk) begin
		if (!reset) begin
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= left_done;
		end
	end

endmodule

/* tb.f */
src/mic_pkg.sv
src/i2s_clock_gen.sv
src/mic_sample_receiver.sv
src/fft_sample_window.sv
src/mic_frontend.sv
dv/mic_frontend_properties.sv
dv/mic_frontend_tb.sv
